// File: laneAddSub.sv
`timescale 1ns/1ps
`include "valu_params.svh"

module laneAddSub (
    input  valuPkg::wordT     rAex,
    input  valuPkg::wordT     rBex,
    input  valuPkg::laneModeT wwEX,
    input  logic              subtract,  // high for sub, a + ~b + 1
    output valuPkg::wordT     sum
);
    localparam int SliceW    = `VALU_BYTE;
    localparam int NumSlices = `VALU_DATA_WIDTH / SliceW;

    valuPkg::wordT bOperand;          // rB or its complement
    logic [0:NumSlices-2] joinNext;   // slice i shares a lane with slice i+1
    logic [0:NumSlices-1] carryIn;
    wire  [1:NumSlices-1] carryOut;   // slice 0 is always a lane top, its carry drops
    wire  [0:SliceW-1]    sliceSum [0:NumSlices-1];

    assign bOperand = subtract ? ~rBex : rBex;

    // lane boundaries between byte slices, slice 0 most significant
    always_comb begin
        unique case (wwEX)
            `VALU_MODE_B: joinNext = 7'b0000000;  // every slice is its own lane
            `VALU_MODE_H: joinNext = 7'b1010101;
            `VALU_MODE_W: joinNext = 7'b1110111;
            `VALU_MODE_D: joinNext = 7'b1111111;  // one 64-bit chain
        endcase
    end

    for (genvar i = 0; i < NumSlices; i++) begin : gSlice
        // carry comes from the next less significant slice
        if (i == NumSlices - 1) begin : gLsb
            assign carryIn[i] = subtract;  // +1 of the two's complement
        end else begin : gChain
            assign carryIn[i] = joinNext[i] ? carryOut[i+1] : subtract;
        end

        if (i == 0) begin : gTop
            assign sliceSum[i] = rAex[i*SliceW +: SliceW] + bOperand[i*SliceW +: SliceW]
                               + {{(SliceW-1){1'b0}}, carryIn[i]};
        end else begin : gBody
            assign {carryOut[i], sliceSum[i]} = {1'b0, rAex[i*SliceW +: SliceW]}
                                              + {1'b0, bOperand[i*SliceW +: SliceW]}
                                              + {{SliceW{1'b0}}, carryIn[i]};
        end
    end

    // gather the slices back into one word
    always_comb begin
        for (int i = 0; i < NumSlices; i++) begin
            sum[i*SliceW +: SliceW] = sliceSum[i];
        end
    end

endmodule

// File: laneMult.sv
`timescale 1ns/1ps
`include "valu_params.svh"

module laneMult (
    input  valuPkg::wordT     rAex,
    input  valuPkg::wordT     rBex,
    input  valuPkg::laneModeT wwEX,
    input  logic              oddSel,  // take lanes 1,3,.. instead of 0,2,..
    input  logic              square,  // rA times itself
    output valuPkg::wordT     product
);
    localparam int HalfW = `VALU_DATA_WIDTH / 2;

    // selected lanes per mode, index 0 byte, 1 half, 2 word
    wire valuPkg::halfT gatherA  [0:2];
    wire valuPkg::halfT gatherB  [0:2];
    wire valuPkg::wordT prodMode [0:2];

    valuPkg::halfT multInA;
    valuPkg::halfT multInB;

    for (genvar m = 0; m < 3; m++) begin : gMode
        localparam int W = (m == 0) ? `VALU_BYTE :
                           (m == 1) ? `VALU_HALF : `VALU_WORD;

        // lane j of the packed operand is lane 2j or 2j+1 of the register
        for (genvar j = 0; j < HalfW / W; j++) begin : gGather
            assign gatherA[m][j*W +: W] = oddSel ? rAex[(2*j+1)*W +: W]
                                                 : rAex[2*j*W +: W];
            assign gatherB[m][j*W +: W] = oddSel ? rBex[(2*j+1)*W +: W]
                                                 : rBex[2*j*W +: W];
        end

        // 4 8x8, 2 16x16, 1 32x32, each product twice the lane width
        for (genvar i = 0; i < HalfW / W; i++) begin : gUnit
            assign prodMode[m][i*2*W +: 2*W] = multInA[i*W +: W] * multInB[i*W +: W];
        end
    end

    // operand select
    always_comb begin
        unique case (wwEX)
            `VALU_MODE_B: begin
                multInA = gatherA[0];
                multInB = gatherB[0];
            end
            `VALU_MODE_H: begin
                multInA = gatherA[1];
                multInB = gatherB[1];
            end
            `VALU_MODE_W: begin
                multInA = gatherA[2];
                multInB = gatherB[2];
            end
            `VALU_MODE_D: begin
                multInA = '0;  // no dword multiplier, keep the array quiet
                multInB = '0;
            end
        endcase
        if (square) begin
            multInB = multInA;  // square variants ignore rB
        end
    end

    // product set for the current lane width
    always_comb begin
        unique case (wwEX)
            `VALU_MODE_B: product = prodMode[0];
            `VALU_MODE_H: product = prodMode[1];
            `VALU_MODE_W: product = prodMode[2];
            `VALU_MODE_D: product = '0;  // 128-bit result does not fit
        endcase
    end

endmodule

// File: laneShift.sv
`timescale 1ns/1ps
`include "valu_params.svh"

module laneShift (
    input  valuPkg::wordT     rAex,
    input  valuPkg::wordT     rBex,
    input  valuPkg::laneModeT wwEX,
    input  logic [1:0]        shiftOp,  // low two bits of the function code
    output valuPkg::wordT     shifted
);
    // op codes as seen in the low bits of the function code
    localparam logic [1:0] OpSll  = 2'(`VALU_F_SLL);   // 2'b10
    localparam logic [1:0] OpSrl  = 2'(`VALU_F_SRL);   // 2'b11
    localparam logic [1:0] OpSra  = 2'(`VALU_F_SRA);   // 2'b00
    localparam logic [1:0] OpRtth = 2'(`VALU_F_RTTH);  // 2'b01

    // one result per lane width, picked by wwEX below
    wire valuPkg::wordT modeRes [0:3];

    for (genvar m = 0; m < 4; m++) begin : gMode
        localparam int W = (m == 0) ? `VALU_BYTE :
                           (m == 1) ? `VALU_HALF :
                           (m == 2) ? `VALU_WORD : `VALU_DATA_WIDTH;
        localparam int SB = $clog2(W);  // shift amount bits per lane

        for (genvar k = 0; k < `VALU_DATA_WIDTH / W; k++) begin : gLane
            logic [0:W-1]  laneA;
            logic [SB-1:0] amt;
            logic [0:W-1]  laneRes;

            assign laneA = rAex[k*W +: W];
            // amount sits in the lsbs of the same lane of rB
            assign amt = rBex[k*W + W - SB +: SB];

            always_comb begin
                unique case (shiftOp)
                    OpSll:  laneRes = laneA << amt;
                    OpSrl:  laneRes = laneA >> amt;
                    OpSra:  laneRes = $signed(laneA) >>> amt;  // fill with lane sign
                    OpRtth: laneRes = {laneA[W/2 +: W/2], laneA[0 +: W/2]};  // swap halves
                endcase
            end

            assign modeRes[m][k*W +: W] = laneRes;
        end
    end

    // mode codes 0..3 line up with the modeRes index
    assign shifted = modeRes[wwEX];

endmodule

// File: valu.f
+incdir+.
valuPkg.sv
laneAddSub.sv
laneShift.sv
laneMult.sv
valuTop.sv
valu_properties.sv
valuTb.sv

// File: valuPkg.sv
`include "valu_params.svh"

package valuPkg;

    // all vectors ascend, so bit 0 is the msb and lane 0 sits at the top
    // of the register

    // full register operand or result
    typedef logic [0:`VALU_DATA_WIDTH-1] wordT;

    // even or odd lanes packed together for the multipliers
    typedef logic [0:`VALU_DATA_WIDTH/2-1] halfT;

    // function code from the decode stage
    typedef logic [0:5] funcT;

    // lane width field
    //   0 byte
    //   1 half-word
    //   2 word
    //   3 double-word
    typedef logic [0:1] laneModeT;

endpackage

// File: valuTb.sv
`timescale 1ns/1ps
`include "valu_params.svh"

module valuTb;

    // test lengths
    localparam int NumLogic  = 8;   // per logic op
    localparam int NumArith  = 6;   // random per mode and op
    localparam int NumShift  = 8;
    localparam int NumMult   = 6;
    localparam int NumRandom = 60;  // mixed ops with idle gaps
    localparam int MaxGap    = 3;

    // issue slots for reset idle, first op, directed groups, unused codes, mix and drain
    localparam int OpSlots = 4 + 1 + 5 * NumLogic + 8 * (NumArith + 2)
                           + 16 * (NumShift + 1) + 16 * (NumMult + 1) + 8
                           + NumRandom * (1 + MaxGap) + 4;
    localparam int TimeoutCycles = 16 + OpSlots + 50;

    logic              clk;
    logic              rstN;
    logic              opValid;
    valuPkg::wordT     rAex;
    valuPkg::wordT     rBex;
    valuPkg::funcT     functionCodeEX;
    valuPkg::laneModeT wwEX;
    valuPkg::wordT     rDex;
    logic              resultValid;

    integer        seed = 14403;
    int            cycleCount = 0;
    valuPkg::wordT expQ [$];          // expected results in issue order
    valuPkg::wordT lastResult = '0;   // rDex must hold this while idle

    valuTop dut_i (
        .clk            (clk),
        .rstN           (rstN),
        .opValid        (opValid),
        .rAex           (rAex),
        .rBex           (rBex),
        .functionCodeEX (functionCodeEX),
        .wwEX           (wwEX),
        .rDex           (rDex),
        .resultValid    (resultValid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abortRun();
        $display("Regression failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic checkWord(input string name, input valuPkg::wordT expVal,
                             input valuPkg::wordT actVal);
        if (actVal !== expVal) begin
            $display("Fail %s expected %h actual %h", name, expVal, actVal);
            abortRun();
        end
    endtask

    task automatic checkValid(input string name, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            $display("Fail %s expected %h actual %h", name, expVal, actVal);
            abortRun();
        end
    endtask

    // expected result in numeric view with lane 0 as the most significant lane
    function automatic valuPkg::wordT refAlu(input valuPkg::wordT a, input valuPkg::wordT b,
                                             input valuPkg::funcT f,
                                             input valuPkg::laneModeT ww);
        logic [63:0] av;
        logic [63:0] bv;
        logic [63:0] res;
        logic [63:0] mask;
        logic [63:0] la;
        logic [63:0] lb;
        logic [63:0] lr;
        int          w;
        int          sh;
        av   = a;
        bv   = b;
        res  = '0;
        w    = 8 << ww;
        mask = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
        case (f)
            `VALU_F_AND: res = av & bv;
            `VALU_F_OR:  res = av | bv;
            `VALU_F_XOR: res = av ^ bv;
            `VALU_F_NOT: res = ~av;
            `VALU_F_MOV: res = av;
            `VALU_F_ADD, `VALU_F_SUB, `VALU_F_SLL,
            `VALU_F_SRL, `VALU_F_SRA, `VALU_F_RTTH: begin
                for (int j = 0; j < 64 / w; j++) begin
                    la = (av >> (j * w)) & mask;
                    lb = (bv >> (j * w)) & mask;
                    sh = int'(lb[5:0]) % w;  // log2(w) low bits of this lane
                    case (f)
                        `VALU_F_ADD: lr = la + lb;
                        `VALU_F_SUB: lr = la - lb;
                        `VALU_F_SLL: lr = la << sh;
                        `VALU_F_SRL: lr = la >> sh;
                        `VALU_F_SRA: begin
                            lr = la >> sh;
                            if (la[w-1]) begin
                                lr = lr | (mask & ~(mask >> sh));  // sign into top bits
                            end
                        end
                        default: lr = (la << (w / 2)) | (la >> (w / 2));  // half swap
                    endcase
                    res = res | ((lr & mask) << (j * w));  // carries cut at the lane
                end
            end
            `VALU_F_MULEU, `VALU_F_MULOU, `VALU_F_SQEU, `VALU_F_SQOU: begin
                if (w != 64) begin
                    // pair p holds lanes 2p (upper half) and 2p+1 (lower half)
                    for (int p = 0; p < 32 / w; p++) begin
                        if (f == `VALU_F_MULOU || f == `VALU_F_SQOU) begin
                            la = (av >> (p * 2 * w)) & mask;
                            lb = (bv >> (p * 2 * w)) & mask;
                        end else begin
                            la = (av >> (p * 2 * w + w)) & mask;
                            lb = (bv >> (p * 2 * w + w)) & mask;
                        end
                        if (f == `VALU_F_SQEU || f == `VALU_F_SQOU) begin
                            lb = la;
                        end
                        lr  = la * lb;  // fits in 2w bits
                        res = res | (lr << (p * 2 * w));
                    end
                end
            end
            default: res = '0;  // spare codes
        endcase
        return res;
    endfunction

    function automatic valuPkg::wordT randWord();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic valuPkg::laneModeT randMode();
        return valuPkg::laneModeT'($random(seed) & 3);
    endfunction

    // a one in the lsb of every lane
    function automatic valuPkg::wordT laneOnes(input valuPkg::laneModeT ww);
        case (ww)
            `VALU_MODE_B: return 64'h0101_0101_0101_0101;
            `VALU_MODE_H: return 64'h0001_0001_0001_0001;
            `VALU_MODE_W: return 64'h0000_0001_0000_0001;
            default:      return 64'h0000_0000_0000_0001;
        endcase
    endfunction

    // one op in one cycle with inputs changing on the falling edge only
    task automatic driveOp(input valuPkg::wordT a, input valuPkg::wordT b,
                           input valuPkg::funcT f, input valuPkg::laneModeT ww);
        rAex           = a;
        rBex           = b;
        functionCodeEX = f;
        wwEX           = ww;
        opValid        = 1'b1;
        expQ.push_back(refAlu(a, b, f, ww));
        @(negedge clk);
        opValid = 1'b0;
    endtask

    // idle with noise on the operands so rDex must hold
    task automatic idleCycles(input int n);
        for (int i = 0; i < n; i++) begin
            opValid        = 1'b0;
            rAex           = randWord();
            rBex           = randWord();
            functionCodeEX = valuPkg::funcT'($random(seed));
            wwEX           = randMode();
            @(negedge clk);
        end
    endtask

    task automatic runLogic();
        valuPkg::funcT codes [0:4];
        codes = '{`VALU_F_AND, `VALU_F_OR, `VALU_F_XOR, `VALU_F_NOT, `VALU_F_MOV};
        foreach (codes[c]) begin
            for (int i = 0; i < NumLogic; i++) begin
                driveOp(randWord(), randWord(), codes[c], randMode());
            end
        end
    endtask

    task automatic runAddSub();
        valuPkg::funcT     codes [0:1];
        valuPkg::laneModeT ww;
        codes = '{`VALU_F_ADD, `VALU_F_SUB};
        for (int m = 0; m < 4; m++) begin
            ww = valuPkg::laneModeT'(m);
            foreach (codes[c]) begin
                for (int i = 0; i < NumArith; i++) begin
                    driveOp(randWord(), randWord(), codes[c], ww);
                end
                driveOp('1, laneOnes(ww), codes[c], ww);  // every lane wraps on add
                driveOp('0, laneOnes(ww), codes[c], ww);  // every lane borrows on sub
            end
        end
    endtask

    task automatic runShifts();
        valuPkg::funcT     codes [0:3];
        valuPkg::laneModeT ww;
        codes = '{`VALU_F_SLL, `VALU_F_SRL, `VALU_F_SRA, `VALU_F_RTTH};
        for (int m = 0; m < 4; m++) begin
            ww = valuPkg::laneModeT'(m);
            foreach (codes[c]) begin
                for (int i = 0; i < NumShift; i++) begin
                    driveOp(randWord(), randWord(), codes[c], ww);
                end
                driveOp(64'h8080_8080_8080_8080, randWord(), codes[c], ww);  // all lanes negative
            end
        end
    endtask

    task automatic runMults();
        valuPkg::funcT     codes [0:3];
        valuPkg::laneModeT ww;
        codes = '{`VALU_F_MULEU, `VALU_F_MULOU, `VALU_F_SQEU, `VALU_F_SQOU};
        for (int m = 0; m < 4; m++) begin
            ww = valuPkg::laneModeT'(m);
            foreach (codes[c]) begin
                for (int i = 0; i < NumMult; i++) begin
                    driveOp(randWord(), randWord(), codes[c], ww);
                end
                driveOp('1, '1, codes[c], ww);  // largest products
            end
        end
    endtask

    task automatic runUnused();
        for (int m = 0; m < 4; m++) begin
            driveOp(randWord(), randWord(), 6'd14, valuPkg::laneModeT'(m));
        end
        driveOp(randWord(), randWord(), 6'd0, randMode());
        driveOp(randWord(), randWord(), 6'd15, randMode());
        driveOp(randWord(), randWord(), 6'd18, randMode());
        driveOp(randWord(), randWord(), 6'd63, randMode());
    endtask

    task automatic runRandomMix();
        valuPkg::funcT codes [0:15];
        int            gap;
        codes = '{`VALU_F_AND, `VALU_F_OR, `VALU_F_XOR, `VALU_F_NOT, `VALU_F_MOV,
                  `VALU_F_ADD, `VALU_F_SUB, `VALU_F_MULEU, `VALU_F_MULOU, `VALU_F_SLL,
                  `VALU_F_SRL, `VALU_F_SRA, `VALU_F_RTTH, `VALU_F_SQEU, `VALU_F_SQOU,
                  6'd14};
        for (int i = 0; i < NumRandom; i++) begin
            driveOp(randWord(), randWord(), codes[$unsigned($random(seed)) % 16], randMode());
            gap = $unsigned($random(seed)) % (MaxGap + 1);  // zero means back to back
            if (gap > 0) begin
                idleCycles(gap);
            end
        end
    endtask

    // stimulus
    initial begin
        rstN           = 1'b0;
        opValid        = 1'b0;
        rAex           = '0;
        rBex           = '0;
        functionCodeEX = '0;
        wwEX           = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        idleCycles(4);  // rDex stays zero and no valid
        driveOp(randWord(), randWord(), `VALU_F_AND, randMode());
        runLogic();
        runAddSub();
        runShifts();
        runMults();
        runUnused();
        runRandomMix();
        idleCycles(4);  // drain
        @(posedge clk);  // last falling edge compare is done by now
        if (expQ.size() != 0) begin
            $display("ERROR: %0d operations never produced a result", expQ.size());
            abortRun();
        end else if (dut_i.props_i.failCount != 0) begin
            $display("ERROR: %0d assertion failures in the bound checker",
                     dut_i.props_i.failCount);
            abortRun();
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

    // compare outputs on the falling edge
    initial begin : compareProc
        valuPkg::wordT expWord;
        logic          opSeen;
        forever begin
            @(posedge clk);
            opSeen = opValid && rstN;  // what the DUT just sampled
            @(negedge clk);
            if (dut_i.props_i.failCount != 0) begin
                $display("ERROR: an assertion in the bound checker fired");
                abortRun();
            end else begin
                checkValid("resultValid", opSeen, resultValid);
                if (!resultValid) begin
                    checkWord("rDex", lastResult, rDex);  // hold or reset value
                end else if (expQ.size() == 0) begin
                    $display("ERROR: resultValid rose with no operation outstanding");
                    abortRun();
                end else begin
                    expWord = expQ.pop_front();
                    checkWord("rDex", expWord, rDex);
                    lastResult = expWord;
                end
            end
        end
    end

    // watchdog
    initial begin
        forever begin
            @(posedge clk);
            cycleCount++;
            if (cycleCount > TimeoutCycles) begin
                $display("ERROR: timeout after %0d cycles, the test did not finish",
                         cycleCount);
                abortRun();
            end
        end
    end

endmodule

// File: valuTop.sv
`timescale 1ns/1ps
`include "valu_params.svh"

module valuTop (
    input  logic              clk,
    input  logic              rstN,
    input  logic              opValid,         // one strobe per operation
    input  valuPkg::wordT     rAex,
    input  valuPkg::wordT     rBex,
    input  valuPkg::funcT     functionCodeEX,
    input  valuPkg::laneModeT wwEX,
    output valuPkg::wordT     rDex,
    output logic              resultValid
);
    // unit controls
    logic       subtract;
    logic [1:0] shiftOp;
    logic       oddSel;
    logic       square;

    // unit results
    valuPkg::wordT sumRes;
    valuPkg::wordT shiftRes;
    valuPkg::wordT prodRes;
    valuPkg::wordT nextResult;  // mux out, registered below

    assign subtract = (functionCodeEX == `VALU_F_SUB);
    assign shiftOp  = functionCodeEX[4:5];  // lsbs tell the four shift ops apart
    assign oddSel   = (functionCodeEX == `VALU_F_MULOU) || (functionCodeEX == `VALU_F_SQOU);
    assign square   = (functionCodeEX == `VALU_F_SQEU) || (functionCodeEX == `VALU_F_SQOU);

    laneAddSub addSub_i (
        .rAex     (rAex),
        .rBex     (rBex),
        .wwEX     (wwEX),
        .subtract (subtract),
        .sum      (sumRes)
    );

    laneShift shift_i (
        .rAex    (rAex),
        .rBex    (rBex),
        .wwEX    (wwEX),
        .shiftOp (shiftOp),
        .shifted (shiftRes)
    );

    laneMult mult_i (
        .rAex    (rAex),
        .rBex    (rBex),
        .wwEX    (wwEX),
        .oddSel  (oddSel),
        .square  (square),
        .product (prodRes)
    );

    // result select, logic ops done here
    always_comb begin
        case (functionCodeEX)
            `VALU_F_AND: nextResult = rAex & rBex;
            `VALU_F_OR:  nextResult = rAex | rBex;
            `VALU_F_XOR: nextResult = rAex ^ rBex;
            `VALU_F_NOT: nextResult = ~rAex;
            `VALU_F_MOV: nextResult = rAex;
            `VALU_F_ADD,
            `VALU_F_SUB: nextResult = sumRes;
            // mult unit already returns zero in dword mode
            `VALU_F_MULEU,
            `VALU_F_MULOU,
            `VALU_F_SQEU,
            `VALU_F_SQOU: nextResult = prodRes;
            `VALU_F_SLL,
            `VALU_F_SRL,
            `VALU_F_SRA,
            `VALU_F_RTTH: nextResult = shiftRes;
            default:      nextResult = '0;  // div, mod, sqrt and spare codes
        endcase
    end

    // one cycle from opValid to resultValid
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rDex        <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= opValid;
            if (opValid) begin
                rDex <= nextResult;  // holds while idle
            end
        end
    end

endmodule

// File: valu_params.svh
`ifndef VALU_PARAMS_SVH
`define VALU_PARAMS_SVH

// operand width and lane widths
`define VALU_DATA_WIDTH 64
`define VALU_BYTE       8
`define VALU_HALF       16
`define VALU_WORD       32

// function codes, bit 0 of funcT is the msb
`define VALU_F_AND   6'd1
`define VALU_F_OR    6'd2
`define VALU_F_XOR   6'd3
`define VALU_F_NOT   6'd4
`define VALU_F_MOV   6'd5
`define VALU_F_ADD   6'd6
`define VALU_F_SUB   6'd7
`define VALU_F_MULEU 6'd8
`define VALU_F_MULOU 6'd9
`define VALU_F_SLL   6'd10
`define VALU_F_SRL   6'd11
`define VALU_F_SRA   6'd12
`define VALU_F_RTTH  6'd13
`define VALU_F_SQEU  6'd16
`define VALU_F_SQOU  6'd17

// ww field, lane width select
`define VALU_MODE_B 2'd0
`define VALU_MODE_H 2'd1
`define VALU_MODE_W 2'd2
`define VALU_MODE_D 2'd3

`endif

// File: valu_properties.sv
`timescale 1ns/1ps

module valuProperties (
    input logic          clk,
    input logic          rstN,
    input logic          opValid,
    input logic          resultValid,
    input valuPkg::wordT rDex
);
    int failCount = 0;  // read by the testbench

    // no valid out of reset
    resetQuiet: assert property (@(posedge clk) !rstN |-> !resultValid)
        else begin
            failCount++;
            $error("resultValid high during reset");
        end

    // valid is opValid delayed by one clock
    validDelay: assert property (@(posedge clk) disable iff (!rstN)
                                 $past(rstN) |-> (resultValid == $past(opValid)))
        else begin
            failCount++;
            $error("resultValid does not follow opValid by one cycle");
        end

    resultKnown: assert property (@(posedge clk) disable iff (!rstN)
                                  resultValid |-> !$isunknown(rDex))
        else begin
            failCount++;
            $error("rDex has unknown bits while resultValid is high");
        end

endmodule

bind valuTop valuProperties props_i (
    .clk         (clk),
    .rstN        (rstN),
    .opValid     (opValid),
    .resultValid (resultValid),
    .rDex        (rDex)
);
